// ==== src/adcfifo_pkg.sv ====
package adcfifo_pkg;

   typedef logic [7:0]  reg_addr_t;
   typedef logic [7:0]  reg_byte_t;
   typedef logic [7:0]  sample_t;
   typedef logic [16:0] threshold_t;
   typedef logic [29:0] ddr_addr_t;
   typedef logic [63:0] ddr_data_t;
   typedef logic [23:0] fifo_stat_t;

   // Host register map
   localparam reg_addr_t addr_adc_read          = 8'h03;
   localparam reg_addr_t addr_fifo_stat         = 8'h10;
   localparam reg_addr_t addr_fifo_state        = 8'h11;
   localparam reg_addr_t addr_adc_low_res       = 8'h12;
   localparam reg_addr_t addr_stream_threshold  = 8'h13;
   localparam reg_addr_t addr_underflow_count   = 8'h14;
   localparam reg_addr_t addr_no_underflow_err  = 8'h15;
   localparam reg_addr_t addr_fifo_config       = 8'h16;
   localparam reg_addr_t addr_fast_read_mode    = 8'h17;
   localparam reg_addr_t addr_ddr_single_data   = 8'h20;
   localparam reg_addr_t addr_ddr_single_addr   = 8'h21;

   localparam threshold_t threshold_reset = 17'd65536;

   // Result of address decode
   typedef enum logic [3:0] {
      sel_none,
      sel_fifo_stat,
      sel_fifo_state,
      sel_adc_low_res,
      sel_stream_threshold,
      sel_underflow_count,
      sel_no_underflow_err,
      sel_fifo_config,
      sel_fast_read_mode,
      sel_adc_read,
      sel_ddr_single_data,
      sel_ddr_single_addr
   } reg_sel_t;

endpackage

// ==== src/reg_access_if.sv ====
`timescale 1ns/10ps

interface reg_access_if #(
   parameter int bytecnt_width = 7
);
   import adcfifo_pkg::*;

   reg_sel_t                 sel;
   logic [bytecnt_width-1:0] bytecnt;
   reg_byte_t                wdata;
   logic                     wr;
   logic                     rd;
   logic                     rd_first;   // First cycle of a read burst

   modport decoder (output sel, bytecnt, wdata, wr, rd, rd_first);
   modport exec    (input  sel, bytecnt, wdata, wr, rd, rd_first);
   modport result  (input  sel, bytecnt, rd);

endinterface

// ==== src/reg_decode.sv ====
`timescale 1ns/10ps

module reg_decode #(
   parameter int bytecnt_width = 7
)(
   input  logic                     clk_usb,
   input  logic                     reset,
   input  adcfifo_pkg::reg_addr_t   reg_address,
   input  logic [bytecnt_width-1:0] reg_bytecnt,
   input  adcfifo_pkg::reg_byte_t   reg_datai,
   input  logic                     reg_read,
   input  logic                     reg_write,
   input  logic                     fast_read_mode,
   reg_access_if.decoder            acc,
   output logic                     fifo_pop
);
   import adcfifo_pkg::*;

   logic rd_q;        // Read level one cycle back
   logic pop_q;
   logic pop_now;

   always_comb begin
      case (reg_address)
         addr_fifo_stat:        acc.sel = sel_fifo_stat;
         addr_fifo_state:       acc.sel = sel_fifo_state;
         addr_adc_low_res:      acc.sel = sel_adc_low_res;
         addr_stream_threshold: acc.sel = sel_stream_threshold;
         addr_underflow_count:  acc.sel = sel_underflow_count;
         addr_no_underflow_err: acc.sel = sel_no_underflow_err;
         addr_fifo_config:      acc.sel = sel_fifo_config;
         addr_fast_read_mode:   acc.sel = sel_fast_read_mode;
         addr_adc_read:         acc.sel = sel_adc_read;
         addr_ddr_single_data:  acc.sel = sel_ddr_single_data;
         addr_ddr_single_addr:  acc.sel = sel_ddr_single_addr;
         default:               acc.sel = sel_none;
      endcase
   end

   assign acc.bytecnt  = reg_bytecnt;
   assign acc.wdata    = reg_datai;
   assign acc.wr       = reg_write;
   assign acc.rd       = reg_read;
   assign acc.rd_first = reg_read & ~rd_q;

   assign pop_now = acc.rd_first && (acc.sel == sel_adc_read);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         rd_q  <= 1'b0;
         pop_q <= 1'b0;
      end else begin
         rd_q  <= reg_read;
         pop_q <= pop_now;
      end
   end

   // Fast mode saves the pipeline cycle
   assign fifo_pop = fast_read_mode ? pop_now : pop_q;

endmodule

// ==== src/fifo_ctrl_regs.sv ====
`timescale 1ns/10ps

module fifo_ctrl_regs #(
   parameter int bytecnt_width = 7
)(
   input  logic                    clk_usb,
   input  logic                    reset,
   reg_access_if.exec              acc,
   input  logic                    single_done,
   output logic                    low_res,
   output logic                    low_res_lsb,
   output adcfifo_pkg::threshold_t stream_segment_threshold,
   output logic                    use_ddr,
   output logic                    data_source_select,
   output logic                    clear_fifo_errors,
   output logic                    no_underflow_errors,
   output logic                    fast_read_mode,
   output logic                    ddr_single_write,
   output logic                    ddr_single_read,
   output adcfifo_pkg::ddr_addr_t  ddr_single_address,
   output adcfifo_pkg::ddr_data_t  ddr_single_write_data
);
   import adcfifo_pkg::*;

   logic single_cmd;   // Byte 3 of the single-access address

   assign single_cmd = acc.wr && (acc.sel == sel_ddr_single_addr) && (acc.bytecnt == 3);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         low_res                  <= 1'b0;
         low_res_lsb              <= 1'b0;
         stream_segment_threshold <= threshold_reset;
         use_ddr                  <= 1'b1;
         data_source_select       <= 1'b1;   // ADC by default
         clear_fifo_errors        <= 1'b0;
         no_underflow_errors      <= 1'b0;
      end else begin
         clear_fifo_errors <= acc.wr && (acc.sel == sel_fifo_stat) && acc.wdata[0];
         if (acc.wr) begin
            case (acc.sel)
               sel_adc_low_res:      {low_res_lsb, low_res} <= acc.wdata[1:0];
               sel_no_underflow_err: no_underflow_errors <= acc.wdata[0];
               sel_fifo_config:      {data_source_select, use_ddr} <= acc.wdata[1:0];
               sel_stream_threshold: begin
                  case (acc.bytecnt)
                     0:       stream_segment_threshold[7:0]  <= acc.wdata;
                     1:       stream_segment_threshold[15:8] <= acc.wdata;
                     2:       stream_segment_threshold[16]   <= acc.wdata[0];
                     default: ;
                  endcase
               end
               default: ;
            endcase
         end
      end
   end

   // Any write elsewhere drops out of fast mode
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         fast_read_mode <= 1'b0;
      end else if (acc.wr) begin
         fast_read_mode <= (acc.sel == sel_fast_read_mode) ? acc.wdata[0] : 1'b0;
      end
   end

   // Single-access address and data
   always_ff @(posedge clk_usb) begin
      if (acc.wr && (acc.sel == sel_ddr_single_addr)) begin
         case (acc.bytecnt)
            0:       ddr_single_address[7:0]   <= acc.wdata;
            1:       ddr_single_address[15:8]  <= acc.wdata;
            2:       ddr_single_address[23:16] <= acc.wdata;
            3:       ddr_single_address[29:24] <= acc.wdata[5:0];
            default: ;
         endcase
      end
      if (acc.wr && (acc.sel == sel_ddr_single_data) && (acc.bytecnt < 8))
         ddr_single_write_data[acc.bytecnt[2:0]*8 +: 8] <= acc.wdata;
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ddr_single_write <= 1'b0;
         ddr_single_read  <= 1'b0;
      end else if (single_done) begin   // Done wins over a new command
         ddr_single_write <= 1'b0;
         ddr_single_read  <= 1'b0;
      end else if (single_cmd) begin
         if (acc.wdata[7])
            ddr_single_write <= 1'b1;
         else
            ddr_single_read <= 1'b1;
      end
   end

endmodule

// ==== src/cdc_pulse.sv ====
`timescale 1ns/10ps

module cdc_pulse (
   input  logic reset,
   input  logic src_clk,
   input  logic src_pulse,
   input  logic dst_clk,
   output logic dst_pulse
);

   logic src_toggle;
   logic [2:0] dst_sync;   // Two sync stages plus history

   always_ff @(posedge src_clk) begin
      if (reset)
         src_toggle <= 1'b0;
      else if (src_pulse)
         src_toggle <= ~src_toggle;
   end

   always_ff @(posedge dst_clk) begin
      if (reset) begin
         dst_sync  <= 3'b000;
         dst_pulse <= 1'b0;
      end else begin
         dst_sync  <= {dst_sync[1:0], src_toggle};
         dst_pulse <= dst_sync[2] ^ dst_sync[1];   // One pulse per edge seen
      end
   end

endmodule

// ==== src/sample_fifo.sv ====
`timescale 1ns/10ps

module sample_fifo #(
   parameter int fifo_depth_log2 = 4
)(
   input  logic                    clk_usb,
   input  logic                    reset,
   input  logic                    push,
   input  adcfifo_pkg::sample_t    sample_in,
   input  logic                    pop,
   input  logic                    clear_errors,
   input  logic                    no_underflow_errors,
   output adcfifo_pkg::sample_t    head,
   output adcfifo_pkg::fifo_stat_t stat,
   output adcfifo_pkg::reg_byte_t  level,
   output adcfifo_pkg::reg_byte_t  underflow_count
);
   import adcfifo_pkg::*;

   localparam int depth = 1 << fifo_depth_log2;

   sample_t mem [depth];
   logic [fifo_depth_log2:0] wr_ptr;   // Extra bit tells full from empty
   logic [fifo_depth_log2:0] rd_ptr;
   logic [fifo_depth_log2:0] count;
   logic empty;
   logic full;
   logic overflow;
   logic underflow;
   logic pop_empty;

   assign count = wr_ptr - rd_ptr;
   assign empty = (wr_ptr == rd_ptr);
   assign full  = count[fifo_depth_log2];
   assign head  = mem[rd_ptr[fifo_depth_log2-1:0]];   // Oldest sample
   assign level = reg_byte_t'(count);
   assign pop_empty = pop && empty && !no_underflow_errors;

   always_ff @(posedge clk_usb) begin
      if (push && !full)
         mem[wr_ptr[fifo_depth_log2-1:0]] <= sample_in;
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push && !full)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop && !empty)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset || clear_errors) begin
         overflow        <= 1'b0;
         underflow       <= 1'b0;
         underflow_count <= '0;
      end else begin
         if (push && full)
            overflow <= 1'b1;   // Sample dropped
         if (pop_empty) begin
            underflow <= 1'b1;
            if (underflow_count != 8'hff)
               underflow_count <= underflow_count + 1'b1;
         end
      end
   end

   always_comb begin
      stat     = '0;
      stat[13] = empty;
      stat[1]  = overflow;
      stat[0]  = underflow;
   end

endmodule

// ==== src/reg_readback.sv ====
`timescale 1ns/10ps

module reg_readback #(
   parameter int bytecnt_width = 7
)(
   reg_access_if.result            acc,
   input  adcfifo_pkg::fifo_stat_t fifo_stat,
   input  adcfifo_pkg::reg_byte_t  fifo_level,
   input  adcfifo_pkg::reg_byte_t  underflow_count,
   input  adcfifo_pkg::sample_t    fifo_head,
   input  logic                    low_res,
   input  logic                    low_res_lsb,
   input  adcfifo_pkg::threshold_t stream_segment_threshold,
   input  logic                    use_ddr,
   input  logic                    data_source_select,
   input  logic                    no_underflow_errors,
   input  logic                    fast_read_mode,
   input  logic                    ddr_single_write,
   input  logic                    ddr_single_read,
   input  adcfifo_pkg::ddr_data_t  ddr_single_read_data,
   output adcfifo_pkg::reg_byte_t  reg_datao
);
   import adcfifo_pkg::*;

   ddr_data_t word;   // Selected register, zero padded to 64 bits
   reg_byte_t byte_sel;

   always_comb begin
      word = '0;
      case (acc.sel)
         sel_fifo_stat:        word = ddr_data_t'(fifo_stat);
         sel_fifo_state:       word = ddr_data_t'(fifo_level);
         sel_adc_low_res:      word = ddr_data_t'({low_res_lsb, low_res});
         sel_stream_threshold: word = ddr_data_t'(stream_segment_threshold);
         sel_underflow_count:  word = ddr_data_t'(underflow_count);
         sel_no_underflow_err: word = ddr_data_t'(no_underflow_errors);
         sel_fifo_config:      word = ddr_data_t'({data_source_select, use_ddr});
         sel_fast_read_mode:   word = ddr_data_t'(fast_read_mode);
         sel_adc_read:         word = ddr_data_t'(fifo_head);
         sel_ddr_single_data:  word = ddr_single_read_data;
         sel_ddr_single_addr:  word = ddr_data_t'({ddr_single_read, ddr_single_write});
         default:              word = '0;
      endcase
   end

   // Bytes past the widest register read as zero
   always_comb begin
      if (acc.bytecnt < 8)
         byte_sel = word[acc.bytecnt[2:0]*8 +: 8];
      else
         byte_sel = '0;
   end

   assign reg_datao = acc.rd ? byte_sel : '0;

endmodule

// ==== src/adc_fifo_subsys.sv ====
`timescale 1ns/10ps

module adc_fifo_subsys #(
   parameter int bytecnt_width   = 7,
   parameter int fifo_depth_log2 = 4
)(
   input  logic                     clk_usb,
   input  logic                     reset,
   input  logic                     ui_clk,
   input  adcfifo_pkg::reg_addr_t   reg_address,
   input  logic [bytecnt_width-1:0] reg_bytecnt,
   input  adcfifo_pkg::reg_byte_t   reg_datai,
   input  logic                     reg_read,
   input  logic                     reg_write,
   input  adcfifo_pkg::sample_t     sample_in,
   input  logic                     sample_wr,
   input  adcfifo_pkg::ddr_data_t   ddr_single_read_data,
   input  logic                     ddr_single_done,     // ui_clk domain
   output adcfifo_pkg::reg_byte_t   reg_datao,
   output logic                     low_res,
   output logic                     low_res_lsb,
   output adcfifo_pkg::threshold_t  stream_segment_threshold,
   output logic                     use_ddr,
   output logic                     data_source_select,
   output logic                     ddr_single_write,
   output logic                     ddr_single_read,
   output adcfifo_pkg::ddr_addr_t   ddr_single_address,
   output adcfifo_pkg::ddr_data_t   ddr_single_write_data
);
   import adcfifo_pkg::*;

   logic       fast_read_mode;
   logic       fifo_pop;
   logic       clear_fifo_errors;
   logic       no_underflow_errors;
   logic       single_done_usb;
   sample_t    fifo_head;
   fifo_stat_t fifo_stat;
   reg_byte_t  fifo_level;
   reg_byte_t  underflow_count;

   reg_access_if #(.bytecnt_width(bytecnt_width)) acc ();

   reg_decode #(.bytecnt_width(bytecnt_width)) u_decode (
      .clk_usb(clk_usb), .reset(reset),
      .reg_address(reg_address), .reg_bytecnt(reg_bytecnt), .reg_datai(reg_datai),
      .reg_read(reg_read), .reg_write(reg_write),
      .fast_read_mode(fast_read_mode), .acc(acc.decoder), .fifo_pop(fifo_pop)
   );

   fifo_ctrl_regs #(.bytecnt_width(bytecnt_width)) u_regs (
      .clk_usb(clk_usb), .reset(reset), .acc(acc.exec), .single_done(single_done_usb),
      .low_res(low_res), .low_res_lsb(low_res_lsb),
      .stream_segment_threshold(stream_segment_threshold),
      .use_ddr(use_ddr), .data_source_select(data_source_select),
      .clear_fifo_errors(clear_fifo_errors), .no_underflow_errors(no_underflow_errors),
      .fast_read_mode(fast_read_mode),
      .ddr_single_write(ddr_single_write), .ddr_single_read(ddr_single_read),
      .ddr_single_address(ddr_single_address), .ddr_single_write_data(ddr_single_write_data)
   );

   // Single-access completion into clk_usb
   cdc_pulse u_done_cdc (
      .reset(reset), .src_clk(ui_clk), .src_pulse(ddr_single_done),
      .dst_clk(clk_usb), .dst_pulse(single_done_usb)
   );

   sample_fifo #(.fifo_depth_log2(fifo_depth_log2)) u_fifo (
      .clk_usb(clk_usb), .reset(reset), .push(sample_wr), .sample_in(sample_in),
      .pop(fifo_pop), .clear_errors(clear_fifo_errors),
      .no_underflow_errors(no_underflow_errors), .head(fifo_head), .stat(fifo_stat),
      .level(fifo_level), .underflow_count(underflow_count)
   );

   reg_readback #(.bytecnt_width(bytecnt_width)) u_readback (
      .acc(acc.result), .fifo_stat(fifo_stat), .fifo_level(fifo_level),
      .underflow_count(underflow_count), .fifo_head(fifo_head),
      .low_res(low_res), .low_res_lsb(low_res_lsb),
      .stream_segment_threshold(stream_segment_threshold),
      .use_ddr(use_ddr), .data_source_select(data_source_select),
      .no_underflow_errors(no_underflow_errors), .fast_read_mode(fast_read_mode),
      .ddr_single_write(ddr_single_write), .ddr_single_read(ddr_single_read),
      .ddr_single_read_data(ddr_single_read_data), .reg_datao(reg_datao)
   );

endmodule

// ==== tb/tb_adc_fifo_tasks.svh ====
// All bus tasks start and end drive_delay after a rising clk_usb edge

task automatic write_reg(input reg_addr_t addr, input int bcnt, input reg_byte_t data);
   reg_address = addr;
   reg_bytecnt = bcnt[bytecnt_width-1:0];
   reg_datai   = data;
   reg_write   = 1'b1;
   @(posedge clk_usb);
   #drive_delay;
   reg_write = 1'b0;
   @(posedge clk_usb);   // Idle cycle lets pulses settle
   #drive_delay;
endtask

// Byte is taken in the first cycle of a burst of ncyc cycles
task automatic read_reg(input reg_addr_t addr, input int bcnt, input int ncyc,
                        output reg_byte_t data);
   reg_address = addr;
   reg_bytecnt = bcnt[bytecnt_width-1:0];
   reg_read    = 1'b1;
   #sample_delay;
   data = reg_datao;
   repeat (ncyc) @(posedge clk_usb);
   #drive_delay;
   reg_read = 1'b0;
   @(posedge clk_usb);   // Low cycle ends the burst
   #drive_delay;
endtask

// Samples the data port in both cycles of a two-cycle read burst
task automatic read_two_cycles(input reg_addr_t addr, output reg_byte_t first,
                               output reg_byte_t second);
   reg_address = addr;
   reg_bytecnt = '0;
   reg_read    = 1'b1;
   #sample_delay;
   first = reg_datao;
   @(posedge clk_usb);
   #(drive_delay + sample_delay);
   second = reg_datao;
   @(posedge clk_usb);
   #drive_delay;
   reg_read = 1'b0;
   @(posedge clk_usb);   // Low cycle ends the burst
   #drive_delay;
endtask

task automatic push_sample(input sample_t s);
   sample_in = s;
   sample_wr = 1'b1;
   @(posedge clk_usb);
   #drive_delay;
   sample_wr = 1'b0;
endtask

// Galois form, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
   return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

task automatic random_byte(output reg_byte_t b);
   b = '0;
   repeat (8) begin
      b = {b[6:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
   end
endtask

task automatic check_byte(input reg_byte_t got, input reg_byte_t expected, input string what);
   checks++;
   if (got !== expected) begin
      $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, got, expected);
      errors++;
   end
endtask

task automatic check_threshold(input threshold_t got, input threshold_t expected,
                               input string what);
   checks++;
   if (got !== expected) begin
      $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, got, expected);
      errors++;
   end
endtask

task automatic check_addr(input ddr_addr_t got, input ddr_addr_t expected, input string what);
   checks++;
   if (got !== expected) begin
      $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, got, expected);
      errors++;
   end
endtask

task automatic check_flag(input logic got, input logic expected, input string what);
   checks++;
   if (got !== expected) begin
      $display("Mismatch at time %0t: %s, got %b, expected %b", $time, what, got, expected);
      errors++;
   end
endtask

// Status word: bit 13 empty, bit 1 overflow, bit 0 underflow
task automatic check_stat(input logic empty, input logic ovf, input logic unf);
   fifo_stat_t exp_stat;
   reg_byte_t  b;
   exp_stat     = '0;
   exp_stat[13] = empty;
   exp_stat[1]  = ovf;
   exp_stat[0]  = unf;
   for (int i = 0; i < 3; i++) begin
      read_reg(addr_fifo_stat, i, 1, b);
      check_byte(b, exp_stat[i*8 +: 8], $sformatf("FIFO status byte %0d", i));
   end
endtask

task automatic fill_fifo(input int n);
   sample_t s;
   repeat (n) begin
      random_byte(s);
      push_sample(s);
      if (expected_q.size() < fifo_depth)
         expected_q.push_back(s);   // Dropped when full
   end
endtask

task automatic drain_samples(input int n);
   reg_byte_t b;
   for (int i = 0; i < n; i++) begin
      read_reg(addr_fifo_state, 0, 1, b);
      check_byte(b, reg_byte_t'(expected_q.size()), "FIFO level before read");
      read_reg(addr_adc_read, 0, (i % 2) * 2 + 1, b);   // Bursts of 1 and 3 cycles
      check_byte(b, expected_q.pop_front(), "FIFO sample");
   end
   read_reg(addr_fifo_state, 0, 1, b);
   check_byte(b, reg_byte_t'(expected_q.size()), "FIFO level after drain");
endtask

// Head moves in the second read cycle only in fast mode
task automatic timed_pop_read(input logic fast);
   reg_byte_t first;
   reg_byte_t second;
   read_two_cycles(addr_adc_read, first, second);
   check_byte(first, expected_q[0], "sample in first read cycle");
   check_byte(second, fast ? expected_q[1] : expected_q[0], "sample in second read cycle");
   expected_q.delete(0);
endtask

task automatic pulse_ddr_done();
   @(posedge ui_clk);
   #drive_delay;
   ddr_single_done = 1'b1;
   @(posedge ui_clk);
   #drive_delay;
   ddr_single_done = 1'b0;
endtask

// Holds a pending single access, completes it and times the flag fall
task automatic finish_single(input logic is_write);
   int   n;
   logic fell;
   repeat (3) @(posedge clk_usb);
   #drive_delay;
   check_flag(is_write ? ddr_single_write : ddr_single_read, 1'b1, "single flag before done");
   pulse_ddr_done();
   fell = 1'b0;
   n    = 0;
   while (!fell && n < 8) begin
      @(posedge clk_usb);
      #drive_delay;
      n++;
      fell = is_write ? !ddr_single_write : !ddr_single_read;
   end
   if (!fell) begin
      $display("Single access flag still high %0d cycles after the done pulse", n);
      errors++;
   end else if (n > 4) begin
      $display("Single access flag fell %0d cycles after the done pulse, limit is 4", n);
      errors++;
   end
endtask

task automatic reset_values();
   reg_byte_t b0, b1, b2, b3;
   read_reg(addr_stream_threshold, 0, 1, b0);
   read_reg(addr_stream_threshold, 1, 1, b1);
   read_reg(addr_stream_threshold, 2, 1, b2);
   read_reg(addr_stream_threshold, 3, 1, b3);
   check_threshold({b2[0], b1, b0}, threshold_reset, "threshold readback after reset");
   check_byte(b2, 8'h01, "threshold byte 2 after reset");
   check_byte(b3, 8'h00, "threshold byte 3 after reset");
   check_threshold(stream_segment_threshold, threshold_reset, "threshold port after reset");
   check_flag(use_ddr, 1'b1, "use_ddr after reset");
   check_flag(data_source_select, 1'b1, "data_source_select after reset");
   check_flag(low_res, 1'b0, "low_res after reset");
   check_flag(low_res_lsb, 1'b0, "low_res_lsb after reset");
   check_flag(ddr_single_write, 1'b0, "ddr_single_write after reset");
   check_flag(ddr_single_read, 1'b0, "ddr_single_read after reset");
   read_reg(addr_fifo_config, 0, 1, b0);
   check_byte(b0, 8'h03, "FIFO config after reset");
   read_reg(addr_adc_low_res, 0, 1, b0);
   check_byte(b0, 8'h00, "low res bits after reset");
   check_stat(1'b1, 1'b0, 1'b0);
endtask

task automatic byte_writes();
   reg_byte_t  wb [4];
   reg_byte_t  rb [3];
   threshold_t exp_thr;
   ddr_addr_t  exp_addr;
   for (int i = 0; i < 3; i++) begin
      random_byte(wb[i]);
      write_reg(addr_stream_threshold, i, wb[i]);
   end
   exp_thr = {wb[2][0], wb[1], wb[0]};
   for (int i = 0; i < 3; i++)
      read_reg(addr_stream_threshold, i, 1, rb[i]);
   check_threshold({rb[2][0], rb[1], rb[0]}, exp_thr, "threshold readback");
   check_byte(rb[2], {7'd0, wb[2][0]}, "threshold byte 2 upper bits");
   check_threshold(stream_segment_threshold, exp_thr, "threshold port");

   // Byte 3 also issues a command, bit 7 picks write or read
   for (int i = 0; i < 4; i++) begin
      random_byte(wb[i]);
      write_reg(addr_ddr_single_addr, i, wb[i]);
   end
   exp_addr = {wb[3][5:0], wb[2], wb[1], wb[0]};
   check_addr(ddr_single_address, exp_addr, "single access address port");
   check_flag(ddr_single_write, wb[3][7], "write flag after random command");
   check_flag(ddr_single_read, !wb[3][7], "read flag after random command");
   finish_single(wb[3][7]);

   read_reg(8'h7e, 0, 1, rb[0]);
   check_byte(rb[0], 8'h00, "unknown address readback");
endtask

task automatic fifo_drain();
   reg_byte_t b;
   fill_fifo(6);
   drain_samples(6);
   write_reg(addr_fast_read_mode, 0, 8'h01);
   read_reg(addr_fast_read_mode, 0, 1, b);
   check_byte(b, 8'h01, "fast read mode set");
   fill_fifo(4);
   timed_pop_read(1'b1);
   drain_samples(1);
   write_reg(addr_adc_low_res, 0, 8'h03);   // Leaves fast mode
   check_flag(low_res, 1'b1, "low_res after write");
   check_flag(low_res_lsb, 1'b1, "low_res_lsb after write");
   read_reg(addr_fast_read_mode, 0, 1, b);
   check_byte(b, 8'h00, "fast read mode after other write");
   timed_pop_read(1'b0);
   drain_samples(1);
   check_stat(1'b1, 1'b0, 1'b0);
endtask

task automatic underflow_overflow();
   reg_byte_t b;
   read_reg(addr_adc_read, 0, 1, b);
   read_reg(addr_adc_read, 0, 2, b);
   check_stat(1'b1, 1'b0, 1'b1);
   read_reg(addr_underflow_count, 0, 1, b);
   check_byte(b, 8'd2, "underflow count after two empty reads");

   write_reg(addr_no_underflow_err, 0, 8'h01);
   read_reg(addr_adc_read, 0, 1, b);
   read_reg(addr_adc_read, 0, 1, b);
   read_reg(addr_underflow_count, 0, 1, b);
   check_byte(b, 8'd2, "underflow count with errors masked");
   write_reg(addr_no_underflow_err, 0, 8'h00);

   write_reg(addr_fifo_stat, 0, 8'h01);
   check_stat(1'b1, 1'b0, 1'b0);
   read_reg(addr_underflow_count, 0, 1, b);
   check_byte(b, 8'd0, "underflow count after clear");

   fill_fifo(fifo_depth + 2);
   check_stat(1'b0, 1'b1, 1'b0);
   write_reg(addr_fifo_stat, 0, 8'h01);
   check_stat(1'b0, 1'b0, 1'b0);
   drain_samples(fifo_depth);   // Dropped samples must not appear
endtask

task automatic single_ddr_access();
   reg_byte_t b;
   ddr_data_t rdata;
   ddr_data_t wdata;
   for (int i = 0; i < 8; i++) begin
      random_byte(b);
      wdata[i*8 +: 8] = b;
      write_reg(addr_ddr_single_data, i, b);
   end
   for (int i = 0; i < 8; i++)
      check_byte(ddr_single_write_data[i*8 +: 8], wdata[i*8 +: 8],
                 $sformatf("single write data byte %0d", i));

   write_reg(addr_ddr_single_addr, 0, 8'h5a);
   write_reg(addr_ddr_single_addr, 1, 8'h3c);
   write_reg(addr_ddr_single_addr, 2, 8'h81);
   write_reg(addr_ddr_single_addr, 3, 8'ha5);
   check_flag(ddr_single_write, 1'b1, "write flag after write command");
   check_flag(ddr_single_read, 1'b0, "read flag after write command");
   check_addr(ddr_single_address, 30'h25813c5a, "address after write command");
   read_reg(addr_ddr_single_addr, 0, 1, b);
   check_byte(b, 8'h01, "single access status, write pending");
   finish_single(1'b1);

   write_reg(addr_ddr_single_addr, 3, 8'h12);
   check_flag(ddr_single_read, 1'b1, "read flag after read command");
   check_flag(ddr_single_write, 1'b0, "write flag after read command");
   check_addr(ddr_single_address, 30'h12813c5a, "address after read command");
   read_reg(addr_ddr_single_addr, 0, 1, b);
   check_byte(b, 8'h02, "single access status, read pending");
   finish_single(1'b0);
   read_reg(addr_ddr_single_addr, 0, 1, b);
   check_byte(b, 8'h00, "single access status when idle");

   for (int i = 0; i < 8; i++) begin
      random_byte(b);
      rdata[i*8 +: 8] = b;
   end
   ddr_single_read_data = rdata;
   for (int i = 0; i < 9; i++) begin
      read_reg(addr_ddr_single_data, i, 1, b);
      check_byte(b, (i < 8) ? rdata[i*8 +: 8] : 8'h00, $sformatf("DDR read data byte %0d", i));
   end
endtask

// ==== tb/tb_adc_fifo.sv ====
`timescale 1ns/10ps

module tb_adc_fifo;
   import adcfifo_pkg::*;

   localparam int bytecnt_width   = 7;
   localparam int fifo_depth_log2 = 4;
   localparam int fifo_depth      = 1 << fifo_depth_log2;
   localparam int clk_period      = 40;
   localparam int ui_half_period  = 13;
   localparam int drive_delay     = 2;
   localparam int sample_delay    = 18;   // Lands on the falling edge
   localparam int num_tests       = 5;

   logic                     clk_usb = 1'b0;
   logic                     ui_clk = 1'b0;
   logic                     reset;
   reg_addr_t                reg_address;
   logic [bytecnt_width-1:0] reg_bytecnt;
   reg_byte_t                reg_datai;
   logic                     reg_read;
   logic                     reg_write;
   sample_t                  sample_in;
   logic                     sample_wr;
   ddr_data_t                ddr_single_read_data;
   logic                     ddr_single_done;
   reg_byte_t                reg_datao;
   logic                     low_res;
   logic                     low_res_lsb;
   threshold_t               stream_segment_threshold;
   logic                     use_ddr;
   logic                     data_source_select;
   logic                     ddr_single_write;
   logic                     ddr_single_read;
   ddr_addr_t                ddr_single_address;
   ddr_data_t                ddr_single_write_data;

   int          errors = 0;
   int          checks = 0;
   logic [15:0] lfsr_state = 16'd8328;
   sample_t     expected_q [$];   // Samples the FIFO should hold, oldest first

   `include "tb_adc_fifo_tasks.svh"

   always #(clk_period / 2) clk_usb = ~clk_usb;
   always #(ui_half_period) ui_clk = ~ui_clk;   // DDR controller clock

   adc_fifo_subsys #(
      .bytecnt_width(bytecnt_width),
      .fifo_depth_log2(fifo_depth_log2)
   ) UUT (
      .clk_usb(clk_usb), .reset(reset), .ui_clk(ui_clk),
      .reg_address(reg_address), .reg_bytecnt(reg_bytecnt), .reg_datai(reg_datai),
      .reg_read(reg_read), .reg_write(reg_write),
      .sample_in(sample_in), .sample_wr(sample_wr),
      .ddr_single_read_data(ddr_single_read_data), .ddr_single_done(ddr_single_done),
      .reg_datao(reg_datao), .low_res(low_res), .low_res_lsb(low_res_lsb),
      .stream_segment_threshold(stream_segment_threshold),
      .use_ddr(use_ddr), .data_source_select(data_source_select),
      .ddr_single_write(ddr_single_write), .ddr_single_read(ddr_single_read),
      .ddr_single_address(ddr_single_address), .ddr_single_write_data(ddr_single_write_data)
   );

   // Watchdog
   initial begin
      #(num_tests * 400 * clk_period);
      $display("Watchdog timeout: the tests did not finish within %0d cycles",
               num_tests * 400);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      reset                = 1'b1;
      reg_address          = '0;
      reg_bytecnt          = '0;
      reg_datai            = '0;
      reg_read             = 1'b0;
      reg_write            = 1'b0;
      sample_in            = '0;
      sample_wr            = 1'b0;
      ddr_single_read_data = '0;
      ddr_single_done      = 1'b0;
      repeat (2) @(posedge clk_usb);
      #drive_delay;
      reset = 1'b0;

      reset_values();
      byte_writes();
      fifo_drain();
      underflow_overflow();
      single_ddr_access();

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+tb
src/adcfifo_pkg.sv
src/reg_access_if.sv
src/reg_decode.sv
src/fifo_ctrl_regs.sv
src/cdc_pulse.sv
src/sample_fifo.sv
src/reg_readback.sv
src/adc_fifo_subsys.sv
tb/tb_adc_fifo.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_adc_fifo
FILELIST  = project.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL
PASS_MSG  = Simulation finished: PASS

SOURCES = $(shell grep -v '^+' $(FILELIST)) tb/tb_adc_fifo_tasks.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Run ended without a result"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
